//--- rtl/pi_pkg.sv
//**********************************************************************
// PI calibration shared definitions
// Code and measurement widths, register map and controller states
//**********************************************************************

package pi_pkg;

  // Interpolator control code, gray coded on the replica
  localparam int code_w = 3;

  // Measured delay and target, in clk cycles
  localparam int meas_w = 8;

  // Word addresses of the register block
  localparam logic [2:0] reg_ctrl   = 3'd0;
  localparam logic [2:0] reg_target = 3'd1;
  localparam logic [2:0] reg_code   = 3'd2;
  localparam logic [2:0] reg_status = 3'd3;
  localparam logic [2:0] reg_meas   = 3'd4;

  // Bit positions inside the ctrl register
  localparam int ctrl_en_bit    = 0;
  localparam int ctrl_start_bit = 1;
  localparam int ctrl_man_bit   = 2;

  // Calibration controller states
  typedef enum logic [2:0] {
    st_idle,     // Waiting for a start
    st_settle,   // Code applied, replica settling
    st_measure,  // Edge timer running
    st_check,    // Compare result against target
    st_done      // Drop busy
  } cal_state_t;

endpackage

//--- rtl/pi_phase_blend.sv
//**********************************************************************
// Phase blender of the replica interpolator
// Eight legs pick between three taps, majority result is registered
//**********************************************************************

`timescale 1ns/1ps

module pi_phase_blend (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] c_in,  // {c, b, a} taps
  input  logic [6:0] sp,    // Thermometer, leg takes tap c when set
  input  logic [6:0] sn,    // Complement, leg takes tap a when set
  output logic       c_out
);

  logic [7:0] leg;
  logic [3:0] ones;

  always_comb begin
    leg[6:0] = (sp & {7{c_in[2]}}) | (sn & {7{c_in[0]}});
    leg[7]   = c_in[1];  // Fixed leg on the middle tap
    ones     = '0;
    for (int i = 0; i < 8; i++) begin
      ones = ones + 4'(leg[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      c_out <= 1'b0;
    end else begin
      c_out <= (ones >= 4'd4);  // Half or more of the legs high
    end
  end

  // Both leg selects come from one decoder in the parent
  assert property (@(posedge clk) disable iff (rst) sn == ~sp)
    else $error("Blender selects sp and sn are not complementary");

endmodule

//--- rtl/pi_replica_interp.sv
//**********************************************************************
// Replica phase interpolator
// Tap delay line with freeze gating, gray decode and p/n blenders
//**********************************************************************

`timescale 1ns/1ps

module pi_replica_interp #(
  parameter int nand_delay = 2  // Tap unit in clk cycles
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      nfrzdrv,
  input  logic                      fout_p,
  input  logic                      fout_n,
  input  logic [pi_pkg::code_w-1:0] gray,
  output logic                      out_p,
  output logic                      out_n,
  output logic                      osc_out_p,
  output logic                      osc_out_n
);

  localparam int depth = 4 * nand_delay + 1;

  logic [depth-1:0] line_p;
  logic [depth-1:0] line_n;
  logic [2:0]       tap_p;
  logic [2:0]       tap_n;
  logic [6:0]       sp;
  logic [6:0]       sn;
  logic             x_p;
  logic             x_n;

  // Frozen line shifts in the rest level of p low and n high
  always_ff @(posedge clk) begin
    if (rst) begin
      line_p <= '0;
      line_n <= '1;
    end else begin
      line_p <= {line_p[depth-2:0], nfrzdrv ? fout_p : 1'b0};
      line_n <= {line_n[depth-2:0], nfrzdrv ? fout_n : 1'b1};
    end
  end

  assign tap_p = {line_p[4*nand_delay], line_p[2*nand_delay], line_p[0]};
  assign tap_n = {line_n[4*nand_delay], line_n[2*nand_delay], line_n[0]};

  // Gray to thermometer decode with ones count equal to the binary code
  always_comb begin
    case (gray)
      3'b000:  sp = 7'b000_0000;
      3'b001:  sp = 7'b000_0001;
      3'b011:  sp = 7'b000_0011;
      3'b010:  sp = 7'b000_0111;
      3'b110:  sp = 7'b000_1111;
      3'b111:  sp = 7'b001_1111;
      3'b101:  sp = 7'b011_1111;
      default: sp = 7'b111_1111;
    endcase
  end

  assign sn = ~sp;

  pi_phase_blend blend_p (
    .clk   (clk),
    .rst   (rst),
    .c_in  (tap_p),
    .sp    (sp),
    .sn    (sn),
    .c_out (x_p)
  );

  pi_phase_blend blend_n (
    .clk   (clk),
    .rst   (rst),
    .c_in  (~tap_n),  // Rising edges blended on both sides
    .sp    (sp),
    .sn    (sn),
    .c_out (x_n)
  );

  assign out_p     = x_p;
  assign out_n     = ~x_n;
  assign osc_out_p = x_p;   // Duplicate oscillator outputs
  assign osc_out_n = ~x_n;

endmodule

//--- rtl/pi_edge_timer.sv
//**********************************************************************
// Edge timer
// Counts clk cycles from a reference rise to the replica rise
//**********************************************************************

`timescale 1ns/1ps

module pi_edge_timer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fout_p,
  input  logic                      osc_out_p,
  input  logic                      meas_start,
  output logic                      meas_done,
  output logic [pi_pkg::meas_w-1:0] meas_value,
  output logic                      meas_ovf
);

  import pi_pkg::*;

  logic              fp_q;
  logic              fp_qq;
  logic              osc_q;
  logic              ref_rise;
  logic              osc_rise;
  logic              armed;     // Waiting for the reference edge
  logic              counting;
  logic [meas_w-1:0] cnt;

  always_ff @(posedge clk) begin
    fp_q  <= fout_p;
    fp_qq <= fp_q;
    osc_q <= osc_out_p;
  end

  assign ref_rise = fp_q & ~fp_qq;
  assign osc_rise = osc_out_p & ~osc_q;  // Replica output is already a flop

  always_ff @(posedge clk) begin
    if (rst) begin
      armed      <= 1'b0;
      counting   <= 1'b0;
      cnt        <= '0;
      meas_done  <= 1'b0;
      meas_value <= '0;
      meas_ovf   <= 1'b0;
    end else begin
      meas_done <= 1'b0;
      if (meas_start && !counting) begin
        armed <= 1'b1;
      end else if (armed && ref_rise) begin
        armed    <= 1'b0;
        counting <= 1'b1;
        cnt      <= meas_w'(1);  // First cycle after the reference rise
      end else if (counting) begin
        if (osc_rise || cnt == '1) begin
          counting   <= 1'b0;
          meas_done  <= 1'b1;
          meas_value <= cnt;
          meas_ovf   <= !osc_rise;  // Saturated without a replica edge
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/pi_wb_regs.sv
//**********************************************************************
// Wishbone classic register block
// Control, target and manual code registers plus status readback
//**********************************************************************

`timescale 1ns/1ps

module pi_wb_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [2:0]                wb_adr,
  input  logic [7:0]                wb_dat_w,
  input  logic                      busy,
  input  logic                      locked,
  input  logic                      cal_error,
  input  logic [pi_pkg::code_w-1:0] lock_code,
  input  logic [pi_pkg::meas_w-1:0] last_meas,
  output logic [7:0]                wb_dat_r,
  output logic                      wb_ack,
  output logic                      enable,
  output logic                      manual,
  output logic [pi_pkg::code_w-1:0] manual_code,
  output logic [pi_pkg::meas_w-1:0] target,
  output logic                      start_pulse
);

  import pi_pkg::*;

  logic       req;
  logic [7:0] rd_mux;

  assign req = wb_cyc && wb_stb && !wb_ack;  // New request with ack not yet given

  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      reg_ctrl: begin
        rd_mux[ctrl_en_bit]  = enable;
        rd_mux[ctrl_man_bit] = manual;  // Start bit reads as zero
      end
      reg_target: rd_mux = 8'(target);
      reg_code:   rd_mux = 8'(manual_code);
      reg_status: rd_mux = {2'b00, lock_code, cal_error, locked, busy};
      reg_meas:   rd_mux = 8'(last_meas);
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack      <= 1'b0;
      enable      <= 1'b0;
      manual      <= 1'b0;
      manual_code <= '0;
      target      <= '0;
      start_pulse <= 1'b0;
    end else begin
      wb_ack      <= req;
      start_pulse <= 1'b0;
      if (req && wb_we) begin
        case (wb_adr)
          reg_ctrl: begin
            enable      <= wb_dat_w[ctrl_en_bit];
            manual      <= wb_dat_w[ctrl_man_bit];
            start_pulse <= wb_dat_w[ctrl_start_bit];
          end
          reg_target: target      <= wb_dat_w[meas_w-1:0];
          reg_code:   manual_code <= wb_dat_w[code_w-1:0];
          default:    ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_mux;  // Held valid through the ack cycle
    end
  end

  // Strobe is only meaningful inside a bus cycle
  assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("Wishbone strobe raised outside a bus cycle");

endmodule

//--- rtl/pi_cal_ctrl.sv
//**********************************************************************
// Calibration controller
// Steps interpolator codes until the measured delay meets the target
//**********************************************************************

`timescale 1ns/1ps

module pi_cal_ctrl #(
  parameter int nand_delay = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable,
  input  logic                      manual,
  input  logic [pi_pkg::code_w-1:0] manual_code,
  input  logic [pi_pkg::meas_w-1:0] target,
  input  logic                      start_pulse,
  input  logic                      meas_done,
  input  logic [pi_pkg::meas_w-1:0] meas_value,
  input  logic                      meas_ovf,
  output logic                      nfrzdrv,
  output logic [pi_pkg::code_w-1:0] gray,
  output logic                      meas_start,
  output logic                      busy,
  output logic                      locked,
  output logic                      cal_error,
  output logic [pi_pkg::code_w-1:0] lock_code,
  output logic [pi_pkg::meas_w-1:0] last_meas
);

  import pi_pkg::*;

  // Longest tap path plus blender and margin
  localparam int settle_cycles = 4 * nand_delay + 4;
  localparam int settle_w      = $clog2(settle_cycles + 1);

  cal_state_t          state;
  logic [settle_w-1:0] settle_cnt;
  logic [code_w-1:0]   trial;     // Binary code under test
  logic                ovf_seen;

  function automatic logic [code_w-1:0] to_gray(input logic [code_w-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      settle_cnt <= '0;
      trial      <= '0;
      ovf_seen   <= 1'b0;
      nfrzdrv    <= 1'b0;
      meas_start <= 1'b0;
      busy       <= 1'b0;
      locked     <= 1'b0;
      cal_error  <= 1'b0;
      lock_code  <= '0;
      last_meas  <= '0;
    end else begin
      nfrzdrv    <= enable;
      meas_start <= 1'b0;
      case (state)
        st_idle: begin
          if (start_pulse && enable) begin  // Starts while busy never reach here
            busy       <= 1'b1;
            locked     <= 1'b0;
            cal_error  <= 1'b0;
            trial      <= '0;
            settle_cnt <= '0;
            state      <= st_settle;
          end
        end
        st_settle: begin
          if (settle_cnt == settle_w'(settle_cycles - 1)) begin
            meas_start <= 1'b1;
            state      <= st_measure;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        st_measure: begin
          if (meas_done) begin
            last_meas <= meas_value;
            ovf_seen  <= meas_ovf;
            state     <= st_check;
          end
        end
        st_check: begin
          if (ovf_seen || (last_meas < target && trial == '1)) begin
            cal_error <= 1'b1;
            lock_code <= '1;
            state     <= st_done;
          end else if (last_meas >= target) begin
            locked    <= 1'b1;
            lock_code <= trial;
            state     <= st_done;
          end else begin
            trial      <= trial + 1'b1;
            settle_cnt <= '0;
            state      <= st_settle;
          end
        end
        st_done: begin
          busy  <= 1'b0;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // A running calibration owns the interpolator code
  always_comb begin
    if (busy) begin
      gray = to_gray(trial);
    end else if (manual) begin
      gray = to_gray(manual_code);
    end else if (locked) begin
      gray = to_gray(lock_code);
    end else begin
      gray = '0;
    end
  end

  // Timer results only arrive while a measurement is pending
  assert property (@(posedge clk) disable iff (rst) meas_done |-> state == st_measure)
    else $error("Measurement result arrived outside the measure state");

endmodule

//--- rtl/pi_cal_top.sv
//**********************************************************************
// Phase interpolator calibration top level
// Register block, controller, replica interpolator and edge timer
//**********************************************************************

`timescale 1ns/1ps

module pi_cal_top #(
  parameter int nand_delay = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       fout_p,
  input  logic       fout_n,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [2:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  output logic       out_p,
  output logic       out_n
);

  import pi_pkg::*;

  logic              enable;
  logic              manual;
  logic [code_w-1:0] manual_code;
  logic [meas_w-1:0] target;
  logic              start_pulse;
  logic              busy;
  logic              locked;
  logic              cal_error;
  logic [code_w-1:0] lock_code;
  logic [meas_w-1:0] last_meas;
  logic              nfrzdrv;
  logic [code_w-1:0] gray;
  logic              meas_start;
  logic              meas_done;
  logic [meas_w-1:0] meas_value;
  logic              meas_ovf;
  logic              osc_p;

  pi_wb_regs i_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .busy        (busy),
    .locked      (locked),
    .cal_error   (cal_error),
    .lock_code   (lock_code),
    .last_meas   (last_meas),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .enable      (enable),
    .manual      (manual),
    .manual_code (manual_code),
    .target      (target),
    .start_pulse (start_pulse)
  );

  pi_cal_ctrl #(
    .nand_delay (nand_delay)
  ) i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .manual      (manual),
    .manual_code (manual_code),
    .target      (target),
    .start_pulse (start_pulse),
    .meas_done   (meas_done),
    .meas_value  (meas_value),
    .meas_ovf    (meas_ovf),
    .nfrzdrv     (nfrzdrv),
    .gray        (gray),
    .meas_start  (meas_start),
    .busy        (busy),
    .locked      (locked),
    .cal_error   (cal_error),
    .lock_code   (lock_code),
    .last_meas   (last_meas)
  );

  pi_replica_interp #(
    .nand_delay (nand_delay)
  ) i_interp (
    .clk       (clk),
    .rst       (rst),
    .nfrzdrv   (nfrzdrv),
    .fout_p    (fout_p),
    .fout_n    (fout_n),
    .gray      (gray),
    .out_p     (out_p),
    .out_n     (out_n),
    .osc_out_p (osc_p),
    .osc_out_n ()         // n oscillator copy not measured
  );

  pi_edge_timer i_timer (
    .clk        (clk),
    .rst        (rst),
    .fout_p     (fout_p),
    .osc_out_p  (osc_p),
    .meas_start (meas_start),
    .meas_done  (meas_done),
    .meas_value (meas_value),
    .meas_ovf   (meas_ovf)
  );

endmodule

//--- verification/tb_clk_gen.sv
//**********************************************************************
// Testbench clock source
// Free running clock with a configurable period
//**********************************************************************

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period = 20.0  // In ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

//--- verification/tb_pi_cal.sv
//**********************************************************************
// Testbench for the PI calibration subsystem
// Wishbone bus tasks, fout stimulus, leg rule model and self checks
//**********************************************************************

`timescale 1ns/1ps

module tb_pi_cal;

  import pi_pkg::*;

  localparam int nd           = 2;     // Tap unit of the DUT
  localparam int ack_timeout  = 8;
  localparam int rise_timeout = 100;
  localparam int out_timeout  = 20;
  localparam int poll_timeout = 1000;

  logic       clk;
  logic       rst;
  logic       fout_p;
  logic       fout_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [2:0] wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic       wb_ack;
  logic       out_p;
  logic       out_n;
  int         half_cnt;
  integer     seed;
  int         errors;

  tb_clk_gen #(.period(20.0)) i_clk_gen (.clk(clk));

  pi_cal_top #(
    .nand_delay (nd)
  ) i_pi_cal_top (
    .clk      (clk),
    .rst      (rst),
    .fout_p   (fout_p),
    .fout_n   (fout_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .out_p    (out_p),
    .out_n    (out_n)
  );

  // Reference clock toggling every 20 clk cycles
  always @(negedge clk) begin
    if (half_cnt == 19) begin
      half_cnt = 0;
      fout_p   = ~fout_p;
      fout_n   = ~fout_p;
    end else begin
      half_cnt = half_cnt + 1;
    end
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("ERR time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Delay of a rising edge in cycles with legs below k on tap c
  function automatic int model_delay(input int k);
    int high;
    for (int t = 0; t <= 4 * nd; t++) begin
      high = (t >= 2 * nd) ? 1 : 0;  // Fixed leg on tap b
      for (int leg = 0; leg < 7; leg++) begin
        if (leg < k) begin
          high = high + ((t >= 4 * nd) ? 1 : 0);
        end else begin
          high = high + 1;             // Tap a is high from t = 0
        end
      end
      if (high >= 4) return t;
    end
    return 4 * nd;
  endfunction

  function automatic int expected_lock(input int tgt);
    for (int k = 0; k < 8; k++) begin
      if (model_delay(k) + 1 >= tgt) return k;
    end
    return 8;  // No code reaches the target
  endfunction

  task automatic bus_cycle(input logic we, input logic [2:0] adr,
                           input logic [7:0] dat, output logic [7:0] rdata);
    int waited;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    while (wb_ack !== 1'b1) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > ack_timeout) begin
        $display("Timeout: Wishbone ack never arrived for address %0d", adr);
        stop_on_error();
      end
    end
    check_val("wb_ack latency", waited, 1);
    rdata  = wb_dat_r;  // Valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic reg_write(input logic [2:0] adr, input logic [7:0] dat);
    logic [7:0] ignored;
    bus_cycle(1'b1, adr, dat, ignored);
  endtask

  task automatic reg_read(input logic [2:0] adr, output logic [7:0] dat);
    bus_cycle(1'b0, adr, 8'h00, dat);
  endtask

  task automatic wait_busy(input logic level);
    logic [7:0] st;
    int         polls;
    polls = 0;
    reg_read(reg_status, st);
    while (st[0] !== level) begin
      polls = polls + 1;
      if (polls > poll_timeout) begin
        $display("Timeout: calibration busy flag never went to %0d", level);
        stop_on_error();
      end
      reg_read(reg_status, st);
    end
  endtask

  // Next fout_p rise must reach out_p after 2+d cycles
  task automatic check_rise_delay(input int k);
    logic prev;
    logic found;
    int   waited;
    int   n;
    @(posedge clk);
    prev   = fout_p;
    found  = 1'b0;
    waited = 0;
    while (!found) begin
      @(posedge clk);
      waited = waited + 1;
      found  = fout_p && !prev;
      prev   = fout_p;
      if (!found && waited > rise_timeout) begin
        $display("Timeout: no rising edge seen on fout_p");
        stop_on_error();
      end
    end
    n     = 0;
    found = 1'b0;
    while (!found) begin
      @(negedge clk);
      n     = n + 1;
      found = (out_p === 1'b1);
      if (!found && n > out_timeout) begin
        $display("Timeout: out_p did not rise after the fout_p edge");
        stop_on_error();
      end
    end
    check_val("out_p delay", n, 2 + model_delay(k));
    check_val("out_n", out_n, 0);
  endtask

  task automatic run_calibration(input int tgt, input logic restart);
    logic [7:0] st;
    logic [7:0] meas;
    int         k;
    reg_write(reg_target, 8'(tgt));
    reg_write(reg_ctrl, 8'h03);    // Enable and start with manual off
    if (restart) begin
      wait_busy(1'b1);
      reg_write(reg_ctrl, 8'h03);  // Second start during the run
    end
    wait_busy(1'b0);
    k = expected_lock(tgt);
    reg_read(reg_status, st);
    reg_read(reg_meas, meas);
    if (k < 8) begin
      check_val("status.locked", st[1], 1);
      check_val("status.error", st[2], 0);
      check_val("status.lock_code", st[5:3], k);
      check_val("meas", meas, model_delay(k) + 1);
    end else begin
      check_val("status.locked", st[1], 0);
      check_val("status.error", st[2], 1);
      check_val("status.lock_code", st[5:3], 7);
    end
  endtask

  initial begin
    logic [7:0] rd;
    int         val;
    int         tgt;
    seed     = 76;
    errors   = 0;
    half_cnt = 0;
    rst      = 1'b1;
    fout_p   = 1'b0;
    fout_n   = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Frozen replica while enable is low
    check_val("wb_ack", wb_ack, 0);
    repeat (100) begin
      @(negedge clk);
      check_val("out_p", out_p, 0);
      check_val("out_n", out_n, 1);
    end
    reg_read(reg_status, rd);
    check_val("status", rd, 0);

    repeat (4) begin
      val = $random(seed) & 8'hff;
      reg_write(reg_target, 8'(val));
      reg_read(reg_target, rd);
      check_val("target", rd, val);
      val = $random(seed) & 8'hff;
      reg_write(reg_code, 8'(val));
      reg_read(reg_code, rd);
      check_val("manual_code", rd, val & 7);
    end
    reg_write(reg_ctrl, 8'h06);  // Start bit with enable low
    reg_read(reg_ctrl, rd);
    check_val("ctrl", rd, 8'h04);

    reg_write(reg_ctrl, 8'h05);  // Enable with manual code
    repeat (4) begin
      val = $random(seed) & 7;
      reg_write(reg_code, 8'(val));
      check_rise_delay(val);
    end

    repeat (3) begin
      tgt = 1 + (($random(seed) & 32'h7fff_ffff) % 9);
      run_calibration(tgt, 1'b0);
    end
    tgt = 10 + ($random(seed) & 8'h7f);  // Beyond the longest delay
    run_calibration(tgt, 1'b0);
    tgt = 1 + (($random(seed) & 32'h7fff_ffff) % 9);
    run_calibration(tgt, 1'b1);

    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

//--- flist.f
rtl/pi_pkg.sv
rtl/pi_phase_blend.sv
rtl/pi_replica_interp.sv
rtl/pi_edge_timer.sv
rtl/pi_wb_regs.sv
rtl/pi_cal_ctrl.sv
rtl/pi_cal_top.sv
verification/tb_clk_gen.sv
verification/tb_pi_cal.sv

//--- Bender.yml
package:
  name: pi_cal

sources:
  - rtl/pi_pkg.sv
  - rtl/pi_phase_blend.sv
  - rtl/pi_replica_interp.sv
  - rtl/pi_edge_timer.sv
  - rtl/pi_wb_regs.sv
  - rtl/pi_cal_ctrl.sv
  - rtl/pi_cal_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_pi_cal.sv
